// File: Bender.yml
package:
  name: wb_xbar

dependencies: {}

sources:
  # Package first, then leaf modules, then the top level
  - xbar_pkg.sv
  - wb_addr_decode.sv
  - wb_err_responder.sv
  - wb_xbar_arbiter.sv
  - wb_req_route.sv
  - wb_rsp_route.sv
  - wb_xbar.sv

  - target: simulation
    files:
      - tb_wb_xbar.sv

// File: project.f
xbar_pkg.sv
wb_addr_decode.sv
wb_err_responder.sv
wb_xbar_arbiter.sv
wb_req_route.sv
wb_rsp_route.sv
wb_xbar.sv
tb_wb_xbar.sv

// File: tb_wb_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb_xbar;

  localparam int TIMEOUT_CYC = 200;
  localparam int ERR_TGT     = 2; // Reference code for the error responder

  logic clk_i;
  logic rst_n_i;

  xbar_pkg::wb_req_t  [xbar_pkg::NUM_INIT-1:0] init_req;
  xbar_pkg::wb_rsp_t  [xbar_pkg::NUM_INIT-1:0] init_rsp;
  xbar_pkg::wb_req_t  [xbar_pkg::NUM_TGT-1:0]  tgt_req;
  xbar_pkg::wb_rsp_t  [xbar_pkg::NUM_TGT-1:0]  tgt_rsp;
  logic               [xbar_pkg::NUM_INIT-1:0] default_en;
  xbar_pkg::tgt_idx_t [xbar_pkg::NUM_INIT-1:0] default_tgt;

  logic [31:0] mem    [2][256]; // Target model storage
  logic [31:0] shadow [2][256]; // Predicted target contents
  integer      seed = 32'h44126cea;
  int          stb_cycles[2];   // Cycles with a strobe seen per target
  bit          both_seen;
  int          done_order[$];   // Initiator of each completed target transfer
  int          errors;
  int          tests_passed;
  int          tests_failed;

  wb_xbar u_dut (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .init_req_i    (init_req),
    .init_rsp_o    (init_rsp),
    .tgt_req_o     (tgt_req),
    .tgt_rsp_i     (tgt_rsp),
    .default_en_i  (default_en),
    .default_tgt_i (default_tgt)
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] fill_word(input int t, input int k);
    return {8'(t + 8'h3c), 8'(k), 8'(~k), 8'(k ^ 8'h5a)};
  endfunction

  // 0x0000_xxxx maps to target 0 and 0x0001_xxxx to target 1
  function automatic int expected_target(input logic [31:0] adr, input logic den,
                                         input int dtgt);
    if (adr[31:16] == 16'h0000) return 0;
    if (adr[31:16] == 16'h0001) return 1;
    if (den && dtgt < 2) return dtgt;
    return ERR_TGT;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                              input logic [31:0] wdat, input logic [3:0] sel);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) res[8*b +: 8] = wdat[8*b +: 8];
    end
    return res;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s, got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("Run stopped: %s", why);
    $display("Tests passed %0d, tests failed %0d", tests_passed, tests_failed + 1);
    $display("Testbench failed");
    $finish;
  endtask

  task automatic finish_test(input string name, input int mark);
    if (errors == mark) begin
      tests_passed++;
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d mismatches", name, errors - mark);
    end
  endtask

  // Memory target model that acks after a random 0 to 3 cycle wait
  task automatic serve_target(input int t);
    xbar_pkg::wb_req_t r;
    bit                busy;
    bit                ack_next;
    int                wait_cnt;
    logic [31:0]       rd;
    logic [7:0]        idx;
    busy     = 1'b0;
    wait_cnt = 0;
    rd       = '0;
    forever begin
      @(negedge clk_i);
      r        = tgt_req[t];
      idx      = r.adr[9:2];
      ack_next = 1'b0;
      if (!rst_n_i || tgt_rsp[t].ack) begin
        busy = 1'b0; // Strobe during the ack cycle is the old transfer
      end else if (r.cyc && r.stb) begin
        if (!busy) begin
          busy     = 1'b1;
          wait_cnt = $unsigned($random(seed)) % 4;
        end
        if (wait_cnt == 0) begin
          ack_next = 1'b1;
          if (r.we) mem[t][idx] = merge_bytes(mem[t][idx], r.dat, r.sel);
          rd = mem[t][idx];
        end else begin
          wait_cnt--;
        end
      end else begin
        busy = 1'b0;
      end
      @(posedge clk_i);
      #2;
      tgt_rsp[t].ack = ack_next;
      tgt_rsp[t].err = 1'b0;
      tgt_rsp[t].dat = ack_next ? rd : '0;
    end
  endtask

  always @(negedge clk_i) begin
    for (int t = 0; t < 2; t++) begin
      if (tgt_req[t].cyc && tgt_req[t].stb) stb_cycles[t]++;
    end
    if (tgt_req[0].stb && tgt_req[1].stb) both_seen = 1'b1;
  end

  // One classic cycle that drops cyc right after ack or err
  task automatic bus_transfer(input int i, input logic we, input logic [31:0] adr,
                              input logic [31:0] wdat, input logic [3:0] sel,
                              output xbar_pkg::wb_rsp_t rsp);
    int n;
    @(posedge clk_i);
    #2;
    init_req[i].cyc = 1'b1;
    init_req[i].stb = 1'b1;
    init_req[i].we  = we;
    init_req[i].adr = adr;
    init_req[i].dat = we ? wdat : '0;
    init_req[i].sel = sel;
    n   = 0;
    rsp = '0;
    do begin
      @(negedge clk_i);
      rsp = init_rsp[i];
      n++;
    end while (!rsp.ack && !rsp.err && n < TIMEOUT_CYC);
    if (!rsp.ack && !rsp.err) begin
      abort_run($sformatf("initiator %0d got neither ack nor err within %0d cycles",
                          i, TIMEOUT_CYC));
    end else begin
      @(posedge clk_i);
      #2;
      init_req[i] = '0;
    end
  endtask

  // Runs one access and compares it with the reference
  task automatic do_access(input int i, input logic we, input logic [31:0] adr,
                           input logic [31:0] wdat, input logic [3:0] sel);
    xbar_pkg::wb_rsp_t rsp;
    int                exp_t;
    int                k;
    string             tag;
    exp_t = expected_target(adr, default_en[i], int'(default_tgt[i]));
    k     = adr[9:2];
    tag   = $sformatf("init %0d %s %h", i, we ? "write" : "read", adr);
    bus_transfer(i, we, adr, wdat, sel, rsp);
    if (exp_t == ERR_TGT) begin
      check_value({tag, " err"}, rsp.err, 1'b1);
      check_value({tag, " ack"}, rsp.ack, 1'b0);
      check_value({tag, " data"}, rsp.dat, '0);
    end else begin
      check_value({tag, " ack"}, rsp.ack, 1'b1);
      check_value({tag, " err"}, rsp.err, 1'b0);
      if (we) begin
        shadow[exp_t][k] = merge_bytes(shadow[exp_t][k], wdat, sel);
        check_value({tag, " landed"}, mem[exp_t][k], shadow[exp_t][k]);
      end else begin
        check_value({tag, " data"}, rsp.dat, shadow[exp_t][k]);
      end
      done_order.push_back(i);
    end
  endtask

  // Write then read back on target 0
  task automatic contend(input int i);
    logic [31:0] adr;
    for (int n = 0; n < 3; n++) begin
      adr = 32'h0000_0100 + 32'(i * 32 + n * 4);
      do_access(i, 1'b1, adr, 32'($random(seed)), 4'hf);
      do_access(i, 1'b0, adr, '0, 4'hf);
    end
  endtask

  initial begin
    int          mark;
    int          stb_before[2];
    logic [31:0] adr;
    logic [31:0] wd0;
    logic [31:0] wd1;
    logic [31:0] adr_list[$];
    rst_n_i      = 1'b0;
    init_req     = '0;
    tgt_rsp      = '0;
    default_en   = '0;
    default_tgt  = '0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    both_seen    = 1'b0;
    for (int t = 0; t < 2; t++) begin
      for (int k = 0; k < 256; k++) begin
        mem[t][k]    = fill_word(t, k);
        shadow[t][k] = fill_word(t, k);
      end
    end
    fork
      serve_target(0);
      serve_target(1);
    join_none
    repeat (2) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;

    mark = errors;
    @(negedge clk_i);
    for (int t = 0; t < 2; t++) begin
      check_value("target cyc after reset", tgt_req[t].cyc, 1'b0);
      check_value("target stb after reset", tgt_req[t].stb, 1'b0);
      check_value("initiator ack after reset", init_rsp[t].ack, 1'b0);
      check_value("initiator err after reset", init_rsp[t].err, 1'b0);
    end
    finish_test("reset idle", mark);

    mark = errors;
    for (int i = 0; i < 2; i++) begin
      for (int t = 0; t < 2; t++) begin
        adr_list.delete();
        for (int n = 0; n < 4; n++) begin
          adr = (32'(t) << 16) | (32'($unsigned($random(seed)) % 256) << 2);
          adr_list.push_back(adr);
          do_access(i, 1'b1, adr, 32'($random(seed)), 4'($random(seed)));
        end
        foreach (adr_list[n]) do_access(i, 1'b0, adr_list[n], '0, 4'hf);
      end
    end
    finish_test("write and read back", mark);

    mark = errors;
    stb_before = stb_cycles;
    do_access(0, 1'b0, 32'h0003_0040, '0, 4'hf);
    do_access(0, 1'b1, 32'h8000_0000, 32'hdead_0001, 4'hf);
    check_value("target 0 strobes on unmapped access", stb_cycles[0], stb_before[0]);
    check_value("target 1 strobes on unmapped access", stb_cycles[1], stb_before[1]);
    finish_test("unmapped error", mark);

    mark = errors;
    default_en[1]  = 1'b1; // Initiator 1 is idle here
    default_tgt[1] = xbar_pkg::tgt_idx_t'(1);
    stb_before     = stb_cycles;
    do_access(1, 1'b1, 32'h0002_0010, 32'h1234_abcd, 4'hf);
    check_value("target 0 strobes on default write", stb_cycles[0], stb_before[0]);
    default_en[1]  = 1'b0;
    do_access(1, 1'b0, 32'h0001_0010, '0, 4'hf);
    finish_test("default target", mark);

    mark = errors;
    done_order.delete();
    fork
      contend(0);
      contend(1);
    join
    check_value("transfers completed", done_order.size(), 12);
    for (int k = 1; k < done_order.size(); k++) begin
      check_value("same initiator twice in a row", done_order[k] == done_order[k-1], 1'b0);
    end
    finish_test("round-robin", mark);

    mark = errors;
    for (int r = 0; r < 3; r++) begin
      wd0       = 32'($random(seed));
      wd1       = 32'($random(seed));
      both_seen = 1'b0;
      fork
        do_access(0, 1'b1, 32'h0000_0200 + 32'(r * 4), wd0, 4'hf);
        do_access(1, 1'b1, 32'h0001_0300 + 32'(r * 4), wd1, 4'hf);
      join
      check_value("parallel strobes in one cycle", both_seen, 1'b1);
      fork
        do_access(0, 1'b0, 32'h0000_0200 + 32'(r * 4), '0, 4'hf);
        do_access(1, 1'b0, 32'h0001_0300 + 32'(r * 4), '0, 4'hf);
      join
    end
    finish_test("parallel targets", mark);

    $display("Tests passed %0d, tests failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: wb_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module wb_addr_decode (
  input  wire  logic [xbar_pkg::ADDR_W-1:0] adr_i,
  input  wire  logic                        default_en_i,
  input  wire  xbar_pkg::tgt_idx_t          default_tgt_i,
  output xbar_pkg::tgt_idx_t                tgt_o
);

  logic default_ok; // Default index names a real target

  assign default_ok = default_en_i &&
                      (default_tgt_i < xbar_pkg::tgt_idx_t'(xbar_pkg::NUM_TGT));

  always_comb begin
    // Miss falls back to the default target or the error responder
    tgt_o = default_ok ? default_tgt_i : xbar_pkg::ERR_IDX;
    for (int t = 0; t < xbar_pkg::NUM_TGT; t++) begin
      if ((adr_i & xbar_pkg::TGT_MASK[t]) == xbar_pkg::TGT_BASE[t]) begin
        tgt_o = xbar_pkg::tgt_idx_t'(t);
      end
    end
  end

endmodule

`default_nettype wire

// File: wb_err_responder.sv
`timescale 1ns/1ps
`default_nettype none

module wb_err_responder (
  input  wire logic         clk_i,
  input  wire logic         rst_n_i,
  input  wire logic         stb_i,
  output xbar_pkg::wb_rsp_t rsp_o
);

  logic busy_q; // High in the cycle the strobe is answered

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else begin
      // Strobe still high during the answer belongs to the old transfer
      busy_q <= stb_i && !busy_q;
    end
  end

  always_comb begin
    rsp_o     = '0;
    rsp_o.err = busy_q; // Never acks, data stays zero
  end

endmodule

`default_nettype wire

// File: wb_req_route.sv
`timescale 1ns/1ps
`default_nettype none

module wb_req_route (
  input  wire  xbar_pkg::wb_req_t   [xbar_pkg::NUM_INIT-1:0] req_i,
  input  wire  xbar_pkg::init_idx_t [xbar_pkg::NUM_TGT-1:0]  owner_i,
  input  wire  logic                [xbar_pkg::NUM_TGT-1:0]  owner_vld_i,
  output xbar_pkg::wb_req_t         [xbar_pkg::NUM_TGT-1:0]  tgt_req_o
);

  always_comb begin
    for (int t = 0; t < xbar_pkg::NUM_TGT; t++) begin
      tgt_req_o[t] = '0; // Unowned target sees an idle bus
      for (int i = 0; i < xbar_pkg::NUM_INIT; i++) begin
        if (owner_vld_i[t] && (owner_i[t] == xbar_pkg::init_idx_t'(i))) begin
          tgt_req_o[t] = req_i[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: wb_rsp_route.sv
`timescale 1ns/1ps
`default_nettype none

module wb_rsp_route (
  input  wire  xbar_pkg::wb_rsp_t  [xbar_pkg::NUM_TGT-1:0]  tgt_rsp_i,
  input  wire  xbar_pkg::wb_rsp_t  [xbar_pkg::NUM_INIT-1:0] err_rsp_i,
  input  wire  xbar_pkg::tgt_idx_t [xbar_pkg::NUM_INIT-1:0] route_i,
  input  wire  logic               [xbar_pkg::NUM_INIT-1:0] route_vld_i,
  output xbar_pkg::wb_rsp_t        [xbar_pkg::NUM_INIT-1:0] init_rsp_o
);

  always_comb begin
    for (int i = 0; i < xbar_pkg::NUM_INIT; i++) begin
      init_rsp_o[i] = '0;
      if (route_vld_i[i]) begin
        // Error responder sits one index above the real targets
        if (route_i[i] == xbar_pkg::ERR_IDX) begin
          init_rsp_o[i] = err_rsp_i[i];
        end else begin
          for (int t = 0; t < xbar_pkg::NUM_TGT; t++) begin
            if (route_i[i] == xbar_pkg::tgt_idx_t'(t)) init_rsp_o[i] = tgt_rsp_i[t];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: wb_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module wb_xbar (
  input  wire  logic                                       clk_i,
  input  wire  logic                                       rst_n_i,
  input  wire  xbar_pkg::wb_req_t  [xbar_pkg::NUM_INIT-1:0] init_req_i,
  output xbar_pkg::wb_rsp_t        [xbar_pkg::NUM_INIT-1:0] init_rsp_o,
  output xbar_pkg::wb_req_t        [xbar_pkg::NUM_TGT-1:0]  tgt_req_o,
  input  wire  xbar_pkg::wb_rsp_t  [xbar_pkg::NUM_TGT-1:0]  tgt_rsp_i,
  input  wire  logic               [xbar_pkg::NUM_INIT-1:0] default_en_i,
  input  wire  xbar_pkg::tgt_idx_t [xbar_pkg::NUM_INIT-1:0] default_tgt_i
);

  xbar_pkg::tgt_idx_t  [xbar_pkg::NUM_INIT-1:0] dec_tgt;   // Decoded target per initiator
  xbar_pkg::init_idx_t [xbar_pkg::NUM_TGT-1:0]  owner;
  logic                [xbar_pkg::NUM_TGT-1:0]  owner_vld;
  xbar_pkg::tgt_idx_t  [xbar_pkg::NUM_INIT-1:0] route;
  logic                [xbar_pkg::NUM_INIT-1:0] route_vld;
  logic                [xbar_pkg::NUM_INIT-1:0] err_stb;
  xbar_pkg::wb_rsp_t   [xbar_pkg::NUM_INIT-1:0] err_rsp;

  // Decoder and error responder per initiator
  for (genvar i = 0; i < xbar_pkg::NUM_INIT; i++) begin : gen_init
    wb_addr_decode u_decode (
      .adr_i         (init_req_i[i].adr),
      .default_en_i  (default_en_i[i]),
      .default_tgt_i (default_tgt_i[i]),
      .tgt_o         (dec_tgt[i])
    );

    wb_err_responder u_err (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .stb_i   (err_stb[i]),
      .rsp_o   (err_rsp[i])
    );
  end

  wb_xbar_arbiter u_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (init_req_i),
    .tgt_i       (dec_tgt),
    .owner_o     (owner),
    .owner_vld_o (owner_vld),
    .route_o     (route),
    .route_vld_o (route_vld),
    .err_stb_o   (err_stb)
  );

  wb_req_route u_req_route (
    .req_i       (init_req_i),
    .owner_i     (owner),
    .owner_vld_i (owner_vld),
    .tgt_req_o   (tgt_req_o)
  );

  // Responses go back only to the owning initiator
  wb_rsp_route u_rsp_route (
    .tgt_rsp_i   (tgt_rsp_i),
    .err_rsp_i   (err_rsp),
    .route_i     (route),
    .route_vld_i (route_vld),
    .init_rsp_o  (init_rsp_o)
  );

endmodule

`default_nettype wire

// File: wb_xbar_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_xbar_arbiter (
  input  wire  logic                                                 clk_i,
  input  wire  logic                                                 rst_n_i,
  input  wire  xbar_pkg::wb_req_t  [xbar_pkg::NUM_INIT-1:0]          req_i,
  input  wire  xbar_pkg::tgt_idx_t [xbar_pkg::NUM_INIT-1:0]          tgt_i,
  output xbar_pkg::init_idx_t      [xbar_pkg::NUM_TGT-1:0]           owner_o,
  output logic                     [xbar_pkg::NUM_TGT-1:0]           owner_vld_o,
  output xbar_pkg::tgt_idx_t       [xbar_pkg::NUM_INIT-1:0]          route_o,
  output logic                     [xbar_pkg::NUM_INIT-1:0]          route_vld_o,
  output logic                     [xbar_pkg::NUM_INIT-1:0]          err_stb_o
);

  // Per-target state
  logic                                          lock_q[xbar_pkg::NUM_TGT];
  xbar_pkg::init_idx_t                           owner_q[xbar_pkg::NUM_TGT];
  xbar_pkg::init_idx_t                           ptr_q[xbar_pkg::NUM_TGT];

  logic [xbar_pkg::NUM_INIT-1:0]                 held;    // Initiator owns a locked target
  logic [xbar_pkg::NUM_TGT-1:0][xbar_pkg::NUM_INIT-1:0] req_vec;
  logic [xbar_pkg::NUM_TGT-1:0]                  gnt_vld;
  xbar_pkg::init_idx_t [xbar_pkg::NUM_TGT-1:0]   gnt_idx;

  // A locked initiator does not compete for another target
  always_comb begin
    held = '0;
    for (int t = 0; t < xbar_pkg::NUM_TGT; t++) begin
      if (lock_q[t]) held[owner_q[t]] = 1'b1;
    end
    for (int t = 0; t < xbar_pkg::NUM_TGT; t++) begin
      for (int i = 0; i < xbar_pkg::NUM_INIT; i++) begin
        req_vec[t][i] = req_i[i].cyc && req_i[i].stb && !held[i] &&
                        (tgt_i[i] == xbar_pkg::tgt_idx_t'(t));
      end
    end
  end

  // Round-robin search from the pointer over free targets
  always_comb begin
    int cand;
    gnt_vld = '0;
    gnt_idx = '0;
    for (int t = 0; t < xbar_pkg::NUM_TGT; t++) begin
      for (int k = 0; k < xbar_pkg::NUM_INIT; k++) begin
        cand = (int'(ptr_q[t]) + k) % xbar_pkg::NUM_INIT;
        if (!lock_q[t] && !gnt_vld[t] && req_vec[t][cand]) begin
          gnt_vld[t] = 1'b1;
          gnt_idx[t] = xbar_pkg::init_idx_t'(cand);
        end
      end
    end
  end

  // Effective owner is the lock, or this cycle's grant
  always_comb begin
    for (int t = 0; t < xbar_pkg::NUM_TGT; t++) begin
      owner_vld_o[t] = lock_q[t] || gnt_vld[t];
      owner_o[t]     = lock_q[t] ? owner_q[t] : gnt_idx[t];
    end
  end

  always_comb begin
    for (int i = 0; i < xbar_pkg::NUM_INIT; i++) begin
      err_stb_o[i] = req_i[i].cyc && req_i[i].stb && !held[i] &&
                     (tgt_i[i] == xbar_pkg::ERR_IDX);
      route_vld_o[i] = 1'b0;
      route_o[i]     = xbar_pkg::ERR_IDX;
      for (int t = 0; t < xbar_pkg::NUM_TGT; t++) begin
        if (owner_vld_o[t] && (owner_o[t] == xbar_pkg::init_idx_t'(i))) begin
          route_vld_o[i] = 1'b1;
          route_o[i]     = xbar_pkg::tgt_idx_t'(t);
        end
      end
      if (!route_vld_o[i] && err_stb_o[i]) route_vld_o[i] = 1'b1; // Local error responder
    end
  end

  always_ff @(posedge clk_i) begin
    for (int t = 0; t < xbar_pkg::NUM_TGT; t++) begin
      if (!rst_n_i) begin
        lock_q[t]  <= 1'b0;
        owner_q[t] <= '0;
        ptr_q[t]   <= '0;
      end else if (lock_q[t]) begin
        if (!req_i[owner_q[t]].cyc) lock_q[t] <= 1'b0; // Owner ended its cycle
      end else if (gnt_vld[t]) begin
        lock_q[t]  <= 1'b1;
        owner_q[t] <= gnt_idx[t];
        // Next search starts just past the winner
        ptr_q[t]   <= (gnt_idx[t] == xbar_pkg::init_idx_t'(xbar_pkg::NUM_INIT - 1)) ?
                      '0 : gnt_idx[t] + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: xbar_pkg.sv
`default_nettype none

package xbar_pkg;

  // Port counts
  localparam int NUM_INIT = 2;
  localparam int NUM_TGT  = 2;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int SEL_W  = DATA_W / 8;

  // A target is hit when (adr & MASK) == BASE
  localparam logic [ADDR_W-1:0] TGT0_BASE = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] TGT0_MASK = 32'hFFFF_0000;
  localparam logic [ADDR_W-1:0] TGT1_BASE = 32'h0001_0000;
  localparam logic [ADDR_W-1:0] TGT1_MASK = 32'hFFFF_0000;

  // Same map as tables indexed by target number
  localparam logic [NUM_TGT-1:0][ADDR_W-1:0] TGT_BASE = {TGT1_BASE, TGT0_BASE};
  localparam logic [NUM_TGT-1:0][ADDR_W-1:0] TGT_MASK = {TGT1_MASK, TGT0_MASK};

  // Initiator to target direction
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat;
    logic [SEL_W-1:0]  sel;
  } wb_req_t;

  // Target to initiator direction
  typedef struct packed {
    logic              ack;
    logic              err;
    logic [DATA_W-1:0] dat;
  } wb_rsp_t;

  // One extra code above the real targets selects the error responder
  typedef logic [$clog2(NUM_TGT+1)-1:0] tgt_idx_t;
  typedef logic [$clog2(NUM_INIT)-1:0]  init_idx_t;

  localparam tgt_idx_t ERR_IDX = tgt_idx_t'(NUM_TGT);

endpackage

`default_nettype wire
